// File: hazardPkg.sv
// Hazard package
// Sizes, register index widths, opcode encoding and execution latencies
// shared by the issue stage blocks

package hazardPkg;

	//////////////////////////////
	// Table and index sizes
	//////////////////////////////

	// In-flight instructions held by the hazard table
	localparam int NumEntryHazard = 8;

	// Entry number, also the ring-buffer pointer width
	localparam int WidthTag = $clog2(NumEntryHazard);

	// Architectural register number
	localparam int WidthReg = 4;

	// Register number plus the scalar/vector unit bit
	localparam int WidthIdx = WidthReg + 1;

	// Latency counter width
	localparam int WidthLat = 8;

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	typedef enum logic [1:0] {
		opAdd    = 2'b00,
		opMul    = 2'b01,
		opLoad   = 2'b10,
		opBranch = 2'b11  // Stalls the offer port until it commits
	} opcodeE;

	//////////////////////////////
	// Execution latency in cycles
	//////////////////////////////

	localparam logic [WidthLat-1:0] LatAdd    = 8'd1;
	localparam logic [WidthLat-1:0] LatMul    = 8'd3;
	localparam logic [WidthLat-1:0] LatLoad   = 8'd12;  // Longest, sets the worst case
	localparam logic [WidthLat-1:0] LatBranch = 8'd2;

endpackage

// File: ringBuffCtrl.sv
// Ring-buffer controller
// Hands out table entries in ascending order and frees them oldest first.
// An occupancy count gives the full and empty flags.

`timescale 1ns/1ns

module ringBuffCtrl (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           writeEnable,  // Allocate at writePtr
	input  logic                           readEnable,   // Free the entry at readPtr
	output logic [hazardPkg::WidthTag-1:0] writePtr,
	output logic [hazardPkg::WidthTag-1:0] readPtr,
	output logic                           full,
	output logic                           empty
);

	logic [hazardPkg::WidthTag:0] count;  // One bit wider to hold a full table

	assign full  = count == (hazardPkg::WidthTag + 1)'(hazardPkg::NumEntryHazard);
	assign empty = count == '0;

	// Pointers wrap on their own, the table size is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr <= '0;
			readPtr  <= '0;
			count    <= '0;
		end else begin
			if (writeEnable)
				writePtr <= writePtr + hazardPkg::WidthTag'(1);
			if (readEnable)
				readPtr <= readPtr + hazardPkg::WidthTag'(1);
			case ({writeEnable, readEnable})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

	// Overflow or underflow would corrupt the in-order release
	assert property (@(posedge clock) disable iff (reset)
		!(writeEnable && full) && !(readEnable && empty))
		else $error("ringBuffCtrl: write when full or read when empty");

endmodule

// File: hazardCheck.sv
// Hazard checker
// Compares each offered instruction against the table of issued but
// uncommitted instructions and refuses it on RAW, WAR or WAW, on a full
// table, or while a branch is in flight. RAR is only reported.
// Accepted instructions are written at the ring write pointer, issued one
// cycle later and cleared again on commit.

`timescale 1ns/1ns

module hazardCheck (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           instrValid,
	input  hazardPkg::opcodeE              instrOp,
	input  logic                           instrIsVec,  // Vector unit operands
	input  logic [hazardPkg::WidthReg-1:0] instrDst,
	input  logic                           instrDstValid,
	input  logic [hazardPkg::WidthReg-1:0] instrSrc1,
	input  logic                           instrSrc1Valid,
	input  logic [hazardPkg::WidthReg-1:0] instrSrc2,
	input  logic                           instrSrc2Valid,
	input  logic                           slice,       // Slicing on, RAR counts
	input  logic                           commitValid,
	input  logic [hazardPkg::WidthTag-1:0] commitTag,
	output logic                           instrReady,
	output logic                           issueValid,
	output hazardPkg::opcodeE              issueOp,
	output logic [hazardPkg::WidthTag-1:0] issueTag,
	output logic [hazardPkg::WidthTag-1:0] rdPtr,       // Oldest entry
	output logic                           rawHazard,
	output logic                           warHazard,
	output logic                           wawHazard,
	output logic                           rarHazard,
	output logic                           branchStall
);

	//////////////////////////////
	// Hazard table
	//////////////////////////////

	logic                           tabValid [hazardPkg::NumEntryHazard];
	hazardPkg::opcodeE              tabOp [hazardPkg::NumEntryHazard];
	logic                           tabBranch [hazardPkg::NumEntryHazard];
	logic [hazardPkg::WidthIdx-1:0] tabDst [hazardPkg::NumEntryHazard];
	logic                           tabDstValid [hazardPkg::NumEntryHazard];
	logic [hazardPkg::WidthIdx-1:0] tabSrc1 [hazardPkg::NumEntryHazard];
	logic                           tabSrc1Valid [hazardPkg::NumEntryHazard];
	logic [hazardPkg::WidthIdx-1:0] tabSrc2 [hazardPkg::NumEntryHazard];
	logic                           tabSrc2Valid [hazardPkg::NumEntryHazard];

	// Unit bit on top, so scalar r3 and vector r3 never meet
	logic [hazardPkg::WidthIdx-1:0] dstIdx;
	logic [hazardPkg::WidthIdx-1:0] src1Idx;
	logic [hazardPkg::WidthIdx-1:0] src2Idx;

	logic [hazardPkg::NumEntryHazard-1:0] rawVec;
	logic [hazardPkg::NumEntryHazard-1:0] warVec;
	logic [hazardPkg::NumEntryHazard-1:0] wawVec;
	logic [hazardPkg::NumEntryHazard-1:0] rarVec;

	logic                           accept;
	logic                           full;
	logic                           empty;
	logic [hazardPkg::WidthTag-1:0] wrPtr;

	assign dstIdx  = {instrIsVec, instrDst};
	assign src1Idx = {instrIsVec, instrSrc1};
	assign src2Idx = {instrIsVec, instrSrc2};

	function automatic logic idxMatch(
		input logic [hazardPkg::WidthIdx-1:0] a,
		input logic                           aValid,
		input logic [hazardPkg::WidthIdx-1:0] b,
		input logic                           bValid
	);
		return aValid && bValid && (a == b);
	endfunction

	//////////////////////////////
	// Dependence comparison
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < hazardPkg::NumEntryHazard; i++) begin
			// Offered source against entry destination
			rawVec[i] = tabValid[i] &
				(idxMatch(src1Idx, instrSrc1Valid, tabDst[i], tabDstValid[i]) |
				 idxMatch(src2Idx, instrSrc2Valid, tabDst[i], tabDstValid[i]));
			// Offered destination against entry sources
			warVec[i] = tabValid[i] &
				(idxMatch(dstIdx, instrDstValid, tabSrc1[i], tabSrc1Valid[i]) |
				 idxMatch(dstIdx, instrDstValid, tabSrc2[i], tabSrc2Valid[i]));
			wawVec[i] = tabValid[i] &
				idxMatch(dstIdx, instrDstValid, tabDst[i], tabDstValid[i]);
			rarVec[i] = tabValid[i] &
				(idxMatch(src1Idx, instrSrc1Valid, tabSrc1[i], tabSrc1Valid[i]) |
				 idxMatch(src1Idx, instrSrc1Valid, tabSrc2[i], tabSrc2Valid[i]) |
				 idxMatch(src2Idx, instrSrc2Valid, tabSrc1[i], tabSrc1Valid[i]) |
				 idxMatch(src2Idx, instrSrc2Valid, tabSrc2[i], tabSrc2Valid[i]));
		end
	end

	// RAR deliberately left out, it never blocks
	assign instrReady = ~full & ~branchStall & ~(|rawVec | |warVec | |wawVec);
	assign accept     = instrValid & instrReady;

	//////////////////////////////
	// Table write and clear
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < hazardPkg::NumEntryHazard; i++)
				tabValid[i] <= 1'b0;
		end else begin
			if (commitValid)
				tabValid[commitTag] <= 1'b0;
			if (accept)
				tabValid[wrPtr] <= 1'b1;  // Never the committing entry
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			tabOp[wrPtr]        <= instrOp;
			tabBranch[wrPtr]    <= instrOp == hazardPkg::opBranch;
			tabDst[wrPtr]       <= dstIdx;
			tabDstValid[wrPtr]  <= instrDstValid;
			tabSrc1[wrPtr]      <= src1Idx;
			tabSrc1Valid[wrPtr] <= instrSrc1Valid;
			tabSrc2[wrPtr]      <= src2Idx;
			tabSrc2Valid[wrPtr] <= instrSrc2Valid;
		end
	end

	//////////////////////////////
	// Issue, flags and branch stall
	//////////////////////////////

	assign issueOp = tabOp[issueTag];  // Entry written on the accepting edge

	always_ff @(posedge clock) begin
		if (reset) begin
			issueValid  <= 1'b0;
			rawHazard   <= 1'b0;
			warHazard   <= 1'b0;
			wawHazard   <= 1'b0;
			rarHazard   <= 1'b0;
			branchStall <= 1'b0;
		end else begin
			issueValid <= accept;
			rawHazard  <= instrValid & |rawVec;
			warHazard  <= instrValid & |warVec;
			wawHazard  <= instrValid & |wawVec;
			rarHazard  <= instrValid & slice & |rarVec;
			if (accept && instrOp == hazardPkg::opBranch)
				branchStall <= 1'b1;
			else if (commitValid && tabBranch[commitTag])
				branchStall <= 1'b0;  // Low from the cycle after commit
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			issueTag <= wrPtr;
	end

	ringBuffCtrl ringBuff (
		.clock       (clock),
		.reset       (reset),
		.writeEnable (accept),
		.readEnable  (commitValid),
		.writePtr    (wrPtr),
		.readPtr     (rdPtr),
		.full        (full),
		.empty       (empty)
	);

	// Commit selector must retire the oldest entry only
	assert property (@(posedge clock) disable iff (reset)
		commitValid |-> !empty && commitTag == rdPtr)
		else $error("hazardCheck: commit of tag %0h, oldest is %0h", commitTag, rdPtr);

	// An accepted instruction never lands on a live entry
	assert property (@(posedge clock) disable iff (reset)
		accept |-> !tabValid[wrPtr])
		else $error("hazardCheck: acceptance into live entry %0h", wrPtr);

endmodule

// File: commitSelect.sv
// Commit selector
// Models execution latency per opcode with one countdown per table entry
// and retires the oldest entry once its countdown has run out.
// Strictly in order, at most one commit per cycle.

`timescale 1ns/1ns

module commitSelect (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           issueValid,
	input  logic [hazardPkg::WidthTag-1:0] issueTag,
	input  hazardPkg::opcodeE              issueOp,
	input  logic [hazardPkg::WidthTag-1:0] rdPtr,       // Oldest in-flight entry
	output logic                           commitValid,
	output logic [hazardPkg::WidthTag-1:0] commitTag
);

	logic                           busy [hazardPkg::NumEntryHazard];
	logic [hazardPkg::WidthLat-1:0] count [hazardPkg::NumEntryHazard];
	logic [hazardPkg::WidthLat-1:0] issueLat;
	logic                           commitFire;

	//////////////////////////////
	// Latency lookup
	//////////////////////////////

	always_comb begin
		case (issueOp)
			hazardPkg::opAdd:    issueLat = hazardPkg::LatAdd;
			hazardPkg::opMul:    issueLat = hazardPkg::LatMul;
			hazardPkg::opLoad:   issueLat = hazardPkg::LatLoad;
			hazardPkg::opBranch: issueLat = hazardPkg::LatBranch;
			default:             issueLat = hazardPkg::LatLoad;
		endcase
	end

	// Oldest entry finished
	assign commitFire = busy[rdPtr] && count[rdPtr] == '0;

	//////////////////////////////
	// Per-entry countdown
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < hazardPkg::NumEntryHazard; i++)
				busy[i] <= 1'b0;
		end else begin
			for (int i = 0; i < hazardPkg::NumEntryHazard; i++) begin
				if (commitFire && rdPtr == hazardPkg::WidthTag'(i))
					busy[i] <= 1'b0;  // Blocks a second commit of this tag
				else if (issueValid && issueTag == hazardPkg::WidthTag'(i))
					busy[i] <= 1'b1;
			end
		end
	end

	// The issue cycle already counts as the first cycle of execution
	always_ff @(posedge clock) begin
		for (int i = 0; i < hazardPkg::NumEntryHazard; i++) begin
			if (issueValid && issueTag == hazardPkg::WidthTag'(i))
				count[i] <= issueLat - hazardPkg::WidthLat'(1);
			else if (count[i] != '0)
				count[i] <= count[i] - hazardPkg::WidthLat'(1);
		end
	end

	//////////////////////////////
	// Commit pulse
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset)
			commitValid <= 1'b0;
		else
			commitValid <= commitFire;
	end

	always_ff @(posedge clock) begin
		if (commitFire)
			commitTag <= rdPtr;
	end

	// Pulse lasts one cycle, the busy bit is gone by then
	assert property (@(posedge clock) disable iff (reset)
		commitValid |=> !commitValid || commitTag != $past(commitTag))
		else $error("commitSelect: tag %0h committed twice in a row", commitTag);

endmodule

// File: issueStage.sv
// Issue stage top level
// Hazard checker in front, commit selector closing the loop back to it.
// Offer port in, issue and commit handshakes out.

`timescale 1ns/1ns

module issueStage (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           instrValid,
	input  hazardPkg::opcodeE              instrOp,
	input  logic                           instrIsVec,
	input  logic [hazardPkg::WidthReg-1:0] instrDst,
	input  logic                           instrDstValid,
	input  logic [hazardPkg::WidthReg-1:0] instrSrc1,
	input  logic                           instrSrc1Valid,
	input  logic [hazardPkg::WidthReg-1:0] instrSrc2,
	input  logic                           instrSrc2Valid,
	input  logic                           slice,
	output logic                           instrReady,
	output logic                           issueValid,
	output hazardPkg::opcodeE              issueOp,
	output logic [hazardPkg::WidthTag-1:0] issueTag,
	output logic                           rawHazard,
	output logic                           warHazard,
	output logic                           wawHazard,
	output logic                           rarHazard,
	output logic                           branchStall,
	output logic                           commitValid,
	output logic [hazardPkg::WidthTag-1:0] commitTag
);

	logic [hazardPkg::WidthTag-1:0] rdPtr;  // Oldest entry, for in-order commit

	hazardCheck hazard (
		.clock          (clock),
		.reset          (reset),
		.instrValid     (instrValid),
		.instrOp        (instrOp),
		.instrIsVec     (instrIsVec),
		.instrDst       (instrDst),
		.instrDstValid  (instrDstValid),
		.instrSrc1      (instrSrc1),
		.instrSrc1Valid (instrSrc1Valid),
		.instrSrc2      (instrSrc2),
		.instrSrc2Valid (instrSrc2Valid),
		.slice          (slice),
		.commitValid    (commitValid),
		.commitTag      (commitTag),
		.instrReady     (instrReady),
		.issueValid     (issueValid),
		.issueOp        (issueOp),
		.issueTag       (issueTag),
		.rdPtr          (rdPtr),
		.rawHazard      (rawHazard),
		.warHazard      (warHazard),
		.wawHazard      (wawHazard),
		.rarHazard      (rarHazard),
		.branchStall    (branchStall)
	);

	commitSelect commit (
		.clock       (clock),
		.reset       (reset),
		.issueValid  (issueValid),
		.issueTag    (issueTag),
		.issueOp     (issueOp),
		.rdPtr       (rdPtr),
		.commitValid (commitValid),
		.commitTag   (commitTag)
	);

endmodule

// File: tbClock.sv
// Testbench clock and reset
// 10 ns clock, synchronous reset held high for the first 10 cycles

`timescale 1ns/1ns

module tbClock (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;  // Half period
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clock);
		@(negedge clock);  // Released away from the sampling edge
		reset = 1'b0;
	end

endmodule

// File: issueStageTb.sv
// Issue stage testbench
// Directed phases with LFSR-picked registers and opcodes. A reference list
// built from the offer and commit handshakes gives the expected ready, hazard
// flags, issue order, commit order and branch stall.

`timescale 1ns/1ns

module issueStageTb;

	localparam int NumOffer  = 29;  // Offers over all phases
	localparam int TimeoutNs = NumOffer * (int'(hazardPkg::LatLoad) + 4) * 10 + 5000;

	logic                           clock;
	logic                           reset;
	logic                           instrValid;
	hazardPkg::opcodeE              instrOp;
	logic                           instrIsVec;
	logic [hazardPkg::WidthReg-1:0] instrDst;
	logic                           instrDstValid;
	logic [hazardPkg::WidthReg-1:0] instrSrc1;
	logic                           instrSrc1Valid;
	logic [hazardPkg::WidthReg-1:0] instrSrc2;
	logic                           instrSrc2Valid;
	logic                           slice;
	logic                           instrReady;
	logic                           issueValid;
	hazardPkg::opcodeE              issueOp;
	logic [hazardPkg::WidthTag-1:0] issueTag;
	logic                           rawHazard;
	logic                           warHazard;
	logic                           wawHazard;
	logic                           rarHazard;
	logic                           branchStall;
	logic                           commitValid;
	logic [hazardPkg::WidthTag-1:0] commitTag;

	// Reference in-flight list, one slot per tag
	logic                           refValid [hazardPkg::NumEntryHazard];
	hazardPkg::opcodeE              refOp [hazardPkg::NumEntryHazard];
	logic [hazardPkg::WidthIdx-1:0] refDst [hazardPkg::NumEntryHazard];
	logic [hazardPkg::WidthIdx-1:0] refSrc1 [hazardPkg::NumEntryHazard];
	logic [hazardPkg::WidthIdx-1:0] refSrc2 [hazardPkg::NumEntryHazard];
	logic                           refDstV [hazardPkg::NumEntryHazard];
	logic                           refSrc1V [hazardPkg::NumEntryHazard];
	logic                           refSrc2V [hazardPkg::NumEntryHazard];
	int                             issueCycle [hazardPkg::NumEntryHazard];

	int                             inFlight;
	int                             cycleCount;
	int                             errors;
	logic                           refStall;
	logic [hazardPkg::WidthTag-1:0] allocTag;      // Next tag to hand out
	logic [hazardPkg::WidthTag-1:0] expIssueTag;
	logic [hazardPkg::WidthTag-1:0] expCommitTag;
	logic                           expIssueQ;
	hazardPkg::opcodeE              expIssueOp;
	logic                           expRaw;
	logic                           expWar;
	logic                           expWaw;
	logic                           expRar;
	logic                           expReady;
	logic                           expRawQ;
	logic                           expWarQ;
	logic                           expWawQ;
	logic                           expRarQ;
	logic                           tbAccept;
	logic                           accepted;      // Acceptance seen at the last edge
	logic [31:0]                    lfsr;

	logic [hazardPkg::WidthIdx-1:0] offDst;
	logic [hazardPkg::WidthIdx-1:0] offSrc1;
	logic [hazardPkg::WidthIdx-1:0] offSrc2;

	tbClock clockGen (
		.clock (clock),
		.reset (reset)
	);

	issueStage UUT (
		.clock          (clock),
		.reset          (reset),
		.instrValid     (instrValid),
		.instrOp        (instrOp),
		.instrIsVec     (instrIsVec),
		.instrDst       (instrDst),
		.instrDstValid  (instrDstValid),
		.instrSrc1      (instrSrc1),
		.instrSrc1Valid (instrSrc1Valid),
		.instrSrc2      (instrSrc2),
		.instrSrc2Valid (instrSrc2Valid),
		.slice          (slice),
		.instrReady     (instrReady),
		.issueValid     (issueValid),
		.issueOp        (issueOp),
		.issueTag       (issueTag),
		.rawHazard      (rawHazard),
		.warHazard      (warHazard),
		.wawHazard      (wawHazard),
		.rarHazard      (rarHazard),
		.branchStall    (branchStall),
		.commitValid    (commitValid),
		.commitTag      (commitTag)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Same unit and same number, both operands present
	function automatic logic sameReg(
		input logic [hazardPkg::WidthIdx-1:0] a,
		input logic                           aV,
		input logic [hazardPkg::WidthIdx-1:0] b,
		input logic                           bV
	);
		return aV && bV && a == b;
	endfunction

	function automatic int latOf(input hazardPkg::opcodeE op);
		case (op)
			hazardPkg::opAdd: return int'(hazardPkg::LatAdd);
			hazardPkg::opMul: return int'(hazardPkg::LatMul);
			hazardPkg::opLoad: return int'(hazardPkg::LatLoad);
			default: return int'(hazardPkg::LatBranch);
		endcase
	endfunction

	task automatic pickBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);  // One step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic pickOp(output hazardPkg::opcodeE op);
		logic [31:0] v;
		pickBits(2, v);
		op = hazardPkg::opcodeE'(v[1:0]);
		if (op == hazardPkg::opBranch)
			op = hazardPkg::opMul;  // Branches only in their own phase
	endtask

	task automatic reportMismatch(input string name, input logic [7:0] got, input logic [7:0] exp);
		errors++;
		$display("mismatch %s: got %h expected %h", name, got, exp);
	endtask

	task automatic reportFailure(input string what);
		errors++;
		$display("%s", what);
	endtask

	// Holds the offer until the DUT takes it, starting on a falling edge
	task automatic offer(
		input hazardPkg::opcodeE              op,
		input logic                           vec,
		input logic [hazardPkg::WidthReg-1:0] dst,
		input logic                           dstV,
		input logic [hazardPkg::WidthReg-1:0] s1,
		input logic                           s1V,
		input logic [hazardPkg::WidthReg-1:0] s2,
		input logic                           s2V,
		input logic                           sl
	);
		instrOp        = op;
		instrIsVec     = vec;
		instrDst       = dst;
		instrDstValid  = dstV;
		instrSrc1      = s1;
		instrSrc1Valid = s1V;
		instrSrc2      = s2;
		instrSrc2Valid = s2V;
		slice          = sl;
		instrValid     = 1'b1;
		do @(negedge clock); while (!accepted);
		instrValid = 1'b0;
	endtask

	task automatic drain();
		while (inFlight != 0)
			@(negedge clock);
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	assign offDst   = {instrIsVec, instrDst};
	assign offSrc1  = {instrIsVec, instrSrc1};
	assign offSrc2  = {instrIsVec, instrSrc2};
	assign tbAccept = instrValid && instrReady;

	always_comb begin
		expRaw = 1'b0;
		expWar = 1'b0;
		expWaw = 1'b0;
		expRar = 1'b0;
		for (int i = 0; i < hazardPkg::NumEntryHazard; i++) begin
			if (refValid[i]) begin
				expRaw |= sameReg(offSrc1, instrSrc1Valid, refDst[i], refDstV[i]) |
					sameReg(offSrc2, instrSrc2Valid, refDst[i], refDstV[i]);
				expWar |= sameReg(offDst, instrDstValid, refSrc1[i], refSrc1V[i]) |
					sameReg(offDst, instrDstValid, refSrc2[i], refSrc2V[i]);
				expWaw |= sameReg(offDst, instrDstValid, refDst[i], refDstV[i]);
				expRar |= sameReg(offSrc1, instrSrc1Valid, refSrc1[i], refSrc1V[i]) |
					sameReg(offSrc1, instrSrc1Valid, refSrc2[i], refSrc2V[i]) |
					sameReg(offSrc2, instrSrc2Valid, refSrc1[i], refSrc1V[i]) |
					sameReg(offSrc2, instrSrc2Valid, refSrc2[i], refSrc2V[i]);
			end
		end
		expReady = inFlight < hazardPkg::NumEntryHazard && !refStall &&
			!(expRaw || expWar || expWaw);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < hazardPkg::NumEntryHazard; i++)
				refValid[i] <= 1'b0;
			inFlight     <= 0;
			cycleCount   <= 0;
			refStall     <= 1'b0;
			allocTag     <= '0;
			expCommitTag <= '0;
			expIssueQ    <= 1'b0;
			expRawQ      <= 1'b0;
			expWarQ      <= 1'b0;
			expWawQ      <= 1'b0;
			expRarQ      <= 1'b0;
			accepted     <= 1'b0;
		end else begin
			if (commitValid) begin
				refValid[commitTag] <= 1'b0;
				expCommitTag <= expCommitTag + hazardPkg::WidthTag'(1);
				if (refOp[commitTag] == hazardPkg::opBranch)
					refStall <= 1'b0;
			end
			if (tbAccept) begin
				refValid[allocTag] <= 1'b1;
				refOp[allocTag]    <= instrOp;
				refDst[allocTag]   <= offDst;
				refDstV[allocTag]  <= instrDstValid;
				refSrc1[allocTag]  <= offSrc1;
				refSrc1V[allocTag] <= instrSrc1Valid;
				refSrc2[allocTag]  <= offSrc2;
				refSrc2V[allocTag] <= instrSrc2Valid;
				allocTag <= allocTag + hazardPkg::WidthTag'(1);
				if (instrOp == hazardPkg::opBranch)
					refStall <= 1'b1;  // Wins over a same-edge clear
			end
			if (issueValid)
				issueCycle[issueTag] <= cycleCount;
			inFlight    <= inFlight + int'(tbAccept) - int'(commitValid);
			cycleCount  <= cycleCount + 1;
			expIssueQ   <= tbAccept;
			expIssueTag <= allocTag;
			expIssueOp  <= instrOp;
			expRawQ     <= instrValid && expRaw;
			expWarQ     <= instrValid && expWar;
			expWawQ     <= instrValid && expWaw;
			expRarQ     <= instrValid && slice && expRar;
			accepted    <= tbAccept;
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	assert property (@(posedge clock) disable iff (reset) instrReady == expReady)
		else reportMismatch("instrReady", 8'($sampled(instrReady)), 8'($sampled(expReady)));
	assert property (@(posedge clock) disable iff (reset) rawHazard == expRawQ)
		else reportMismatch("rawHazard", 8'($sampled(rawHazard)), 8'($sampled(expRawQ)));
	assert property (@(posedge clock) disable iff (reset) warHazard == expWarQ)
		else reportMismatch("warHazard", 8'($sampled(warHazard)), 8'($sampled(expWarQ)));
	assert property (@(posedge clock) disable iff (reset) wawHazard == expWawQ)
		else reportMismatch("wawHazard", 8'($sampled(wawHazard)), 8'($sampled(expWawQ)));
	assert property (@(posedge clock) disable iff (reset) rarHazard == expRarQ)
		else reportMismatch("rarHazard", 8'($sampled(rarHazard)), 8'($sampled(expRarQ)));
	assert property (@(posedge clock) disable iff (reset) issueValid == expIssueQ)
		else reportMismatch("issueValid", 8'($sampled(issueValid)), 8'($sampled(expIssueQ)));
	assert property (@(posedge clock) disable iff (reset)
		issueValid |-> issueTag == expIssueTag)
		else reportMismatch("issueTag", 8'($sampled(issueTag)), 8'($sampled(expIssueTag)));
	assert property (@(posedge clock) disable iff (reset)
		issueValid |-> issueOp == expIssueOp)
		else reportMismatch("issueOp", 8'($sampled(issueOp)), 8'($sampled(expIssueOp)));
	assert property (@(posedge clock) disable iff (reset)
		commitValid |-> commitTag == expCommitTag)
		else reportMismatch("commitTag", 8'($sampled(commitTag)), 8'($sampled(expCommitTag)));
	assert property (@(posedge clock) disable iff (reset) commitValid |-> refValid[commitTag])
		else reportFailure("commit of a tag that is not in flight");
	// Registered pulse, so one cycle past the countdown at the earliest
	assert property (@(posedge clock) disable iff (reset)
		commitValid |-> cycleCount - issueCycle[commitTag] > latOf(refOp[commitTag]))
		else reportFailure("commit came before the execution latency ran out");
	assert property (@(posedge clock) disable iff (reset) branchStall == refStall)
		else reportMismatch("branchStall", 8'($sampled(branchStall)), 8'($sampled(refStall)));

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		logic [31:0]                    v;
		hazardPkg::opcodeE              op;
		logic [hazardPkg::WidthReg-1:0] r;
		lfsr           = 32'hb460e9f9;
		errors         = 0;
		instrValid     = 1'b0;
		instrOp        = hazardPkg::opAdd;
		instrIsVec     = 1'b0;
		instrDst       = '0;
		instrDstValid  = 1'b0;
		instrSrc1      = '0;
		instrSrc1Valid = 1'b0;
		instrSrc2      = '0;
		instrSrc2Valid = 1'b0;
		slice          = 1'b0;
		@(negedge clock);
		while (reset)
			@(negedge clock);

		// Independent stream, destinations low half, sources high half
		for (int i = 0; i < 8; i++) begin
			pickOp(op);
			offer(op, 1'b0, 4'(i), 1'b1, 4'(8 + i), 1'b1, 4'd0, 1'b0, 1'b0);
		end
		drain();

		pickBits(4, v);
		r = v[3:0];
		// RAW, the vector reader goes at once, the scalar one waits
		offer(hazardPkg::opLoad, 1'b0, r, 1'b1, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0);
		offer(hazardPkg::opAdd, 1'b1, r + 4'd2, 1'b1, r, 1'b1, 4'd0, 1'b0, 1'b0);
		offer(hazardPkg::opAdd, 1'b0, r + 4'd3, 1'b1, r, 1'b1, 4'd0, 1'b0, 1'b0);
		drain();

		// WAR then WAW
		pickOp(op);
		offer(hazardPkg::opLoad, 1'b0, r + 4'd4, 1'b1, r, 1'b1, 4'd0, 1'b0, 1'b0);
		offer(op, 1'b0, r, 1'b1, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0);
		drain();
		offer(hazardPkg::opLoad, 1'b0, r, 1'b1, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0);
		offer(op, 1'b0, r, 1'b1, 4'd0, 1'b0, r + 4'd5, 1'b1, 1'b0);
		drain();

		// RAR with and without slicing
		offer(hazardPkg::opLoad, 1'b0, r + 4'd6, 1'b1, r, 1'b1, 4'd0, 1'b0, 1'b0);
		offer(hazardPkg::opAdd, 1'b0, r + 4'd7, 1'b1, r, 1'b1, 4'd0, 1'b0, 1'b1);
		offer(hazardPkg::opAdd, 1'b0, r + 4'd8, 1'b1, 4'd0, 1'b0, r, 1'b1, 1'b0);
		drain();

		// Branch stall
		offer(hazardPkg::opBranch, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0);
		offer(hazardPkg::opAdd, 1'b0, r, 1'b1, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0);
		drain();

		// Full table, the ninth load waits for the first commit
		for (int i = 0; i < 9; i++)
			offer(hazardPkg::opLoad, 1'b0, 4'(i), 1'b1, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0);
		drain();

		repeat (4) @(negedge clock);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		#(TimeoutNs);
		$display("timeout: the run did not finish within %0d ns", TimeoutNs);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: issueStage.f
hazardPkg.sv
ringBuffCtrl.sv
hazardCheck.sv
commitSelect.sv
issueStage.sv
tbClock.sv
issueStageTb.sv

// File: run.sh
#!/bin/sh
# Builds the issue stage testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal --top-module issueStageTb -f issueStage.f

out=$(./obj_dir/VissueStageTb)
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1
